/* src.f */
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_alu.sv
verilog/rv_exu.sv
verilog/rv_gpr.sv
verilog/rv_idu.sv
verilog/rv_ifu.sv
verilog/rv_core.sv
sim/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim/rv_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_core_tb;

	localparam int N_INST = 2000;
	localparam logic [31:0] SEED = 32'hdf93_2cf9;

	logic                    clk;
	logic                    rst_n;
	logic                    imem_req;
	logic [`XLEN-1:0]        imem_addr;
	logic [31:0]             imem_rdata = '0;
	rv_core_pkg::dmem_req_t  dmem_req;
	logic [`XLEN-1:0]        dmem_rdata = '0;

	// instruction-set model state
	logic [31:0]  rnd_state = SEED;
	logic [31:0]  m_pc = `RESET_PC;
	logic [31:0]  xreg [0:31] = '{default: '0};
	logic [7:0]   mem [logic [31:0]];    // bytes written so far
	logic [1:0]   exp_kind = 2'd0;       // 1 is a load, 2 is a store
	logic [31:0]  exp_addr = '0;
	logic [3:0]   exp_mask = '0;
	logic [31:0]  exp_wdata = '0;
	logic         last_load = 1'b0;
	logic [31:0]  next_ins = '0;
	int           n_issued = 0;
	int           cyc = 0;
	int           rst_cyc = 0;
	int           last_fetch = 0;

	rv_core uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_req   (imem_req),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	// failure reporting and random numbers

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic value_error(input string what);
		fail_now($sformatf("[ERROR] %0t ns: %s", $time, what));
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] next_rand();
		rnd_state = lcg_step(rnd_state);
		return rnd_state ^ (rnd_state >> 16);    // low lcg bits are weak
	endfunction

	function logic [4:0] pick_reg();
		logic [31:0] r;
		r = next_rand();
		return {r[2:0], 2'b00};    // pool of eight registers, x0 included
	endfunction

	// unwritten bytes come from a hash of the full address
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] h;
		h = lcg_step(lcg_step(a ^ SEED));
		return mem.exists(a) ? mem[a] : h[31:24];
	endfunction

	function automatic logic [31:0] load_word(input logic [31:0] a);
		return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), mem_byte(a + 32'd1), mem_byte(a)};
	endfunction

	function automatic logic [3:0] width_mask(input logic [2:0] f3);
		case (f3[1:0])
			2'b00:   return 4'b0001;
			2'b01:   return 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end else begin
					return a >> b[4:0];
				end
			end
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;
		endcase
	endfunction

	// --------------------------------------------------
	// builds one random instruction and retires it in the model

	task automatic issue_inst(output logic [31:0] ins);
		logic [31:0] r;
		logic [31:0] imm;
		logic [31:0] iimm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] w;
		logic [31:0] s;
		logic [31:0] res;
		logic [31:0] npc;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		logic        wr;
		int          kind;
		r = next_rand();
		imm = next_rand();
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		f3 = r[10:8];
		alt = r[11];
		a = xreg[rs1];
		b = xreg[rs2];
		iimm = {{20{imm[11]}}, imm[11:0]};
		res = '0;
		wr = 1'b1;
		npc = m_pc + 32'd4;
		kind = int'(r % 32'd100);
		last_load = 1'b0;
		if (kind < 10) begin
			f3 = (r[9:8] == 2'b11) ? 3'd2 : {1'b0, r[9:8]};
			s = a + iimm;
			exp_kind = 2'd2;
			exp_addr = s;
			exp_mask = width_mask(f3);
			exp_wdata = (f3 == 3'd0) ? {4{b[7:0]}} : (f3 == 3'd1) ? {2{b[15:0]}} : b;
			for (int i = 0; i < 4; i++) begin
				if (exp_mask[i]) begin
					mem[s + i] = b[8*i +: 8];
				end
			end
			wr = 1'b0;
			ins = {iimm[11:5], rs2, rs1, f3, iimm[4:0], `OPC_STORE};
		end else if (kind < 20) begin
			f3 = {r[10], 1'b0, r[8]};
			if (r[9] && !r[10]) begin
				f3 = 3'd2;
			end
			s = a + iimm;
			exp_kind = 2'd1;
			exp_addr = s;
			exp_mask = width_mask(f3);
			w = load_word(s);
			case (f3)
				3'd0:    res = {{24{w[7]}}, w[7:0]};
				3'd1:    res = {{16{w[15]}}, w[15:0]};
				3'd4:    res = {24'b0, w[7:0]};
				3'd5:    res = {16'b0, w[15:0]};
				default: res = w;
			endcase
			last_load = 1'b1;
			ins = {iimm[11:0], rs1, f3, rd, `OPC_LOAD};
		end else if (kind < 40) begin
			alt = alt && (f3 == 3'd0 || f3 == 3'd5);
			res = alu_result(f3, alt, a, b);
			ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
		end else if (kind < 60) begin
			alt = alt && (f3 == 3'd5);
			if (f3 == 3'd1 || f3 == 3'd5) begin
				imm[11:5] = {1'b0, alt, 5'b0};    // shift amount form
			end
			iimm = {{20{imm[11]}}, imm[11:0]};
			res = alu_result(f3, alt, a, iimm);
			ins = {imm[11:0], rs1, f3, rd, `OPC_OPIMM};
		end else if (kind < 72) begin
			if (f3[2:1] == 2'b01) begin
				f3[1] = 1'b0;
			end
			s = {{19{imm[12]}}, imm[12:2], 2'b00};
			if (branch_taken(f3, a, b)) begin
				npc = m_pc + s;
			end
			wr = 1'b0;
			ins = {s[12], s[10:5], rs2, rs1, f3, s[4:1], s[11], `OPC_BRANCH};
		end else if (kind < 78) begin
			res = {imm[31:12], 12'b0};
			ins = {imm[31:12], rd, `OPC_LUI};
		end else if (kind < 84) begin
			res = m_pc + {imm[31:12], 12'b0};
			ins = {imm[31:12], rd, `OPC_AUIPC};
		end else if (kind < 92) begin
			s = {{11{imm[20]}}, imm[20:2], 2'b00};
			res = m_pc + 32'd4;
			npc = m_pc + s;
			ins = {s[20], s[10:1], s[11], s[19:12], rd, `OPC_JAL};
		end else begin
			s = a + iimm;
			if (s[1]) begin
				imm[1] = !imm[1];    // keeps the target word aligned, bit 0 stays random
				iimm = {{20{imm[11]}}, imm[11:0]};
				s = a + iimm;
			end
			res = m_pc + 32'd4;
			npc = {s[31:1], 1'b0};
			ins = {iimm[11:0], rs1, 3'b000, rd, `OPC_JALR};
		end
		if (wr && rd != 5'd0) begin
			xreg[rd] = res;
		end
		m_pc = npc;
	endtask

	// --------------------------------------------------
	// memory models and checks at every rising edge

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!rst_n) begin
			rst_cyc = cyc;
			if (cyc > 1) begin
				assert (!imem_req && !dmem_req.ren && !dmem_req.wen)
					else value_error("request strobe high under reset");
			end
		end else begin
			if (imem_req) begin
				if (n_issued == 0) begin
					assert (cyc - rst_cyc <= 2)
						else value_error($sformatf("first fetch %0d cycles after reset",
							cyc - rst_cyc));
				end else begin
					assert (cyc - last_fetch == (last_load ? 3 : 2))
						else value_error($sformatf("fetch spacing %0d cycles",
							cyc - last_fetch));
				end
				assert (imem_addr == m_pc)
					else value_error($sformatf("fetch address %h, expected %h",
						imem_addr, m_pc));
				assert (exp_kind == 2'd0)
					else value_error("expected data memory request did not appear");
				last_fetch = cyc;
				issue_inst(next_ins);
				imem_rdata <= next_ins;
				n_issued = n_issued + 1;
			end
			if (dmem_req.ren || dmem_req.wen) begin
				assert (!(dmem_req.ren && dmem_req.wen))
					else value_error("data read and write enables high together");
				assert (exp_kind == (dmem_req.wen ? 2'd2 : 2'd1))
					else value_error($sformatf("unexpected data request ren %b wen %b",
						dmem_req.ren, dmem_req.wen));
				assert (dmem_req.addr == exp_addr && dmem_req.mask == exp_mask)
					else value_error($sformatf("data address %h mask %b, expected %h %b",
						dmem_req.addr, dmem_req.mask, exp_addr, exp_mask));
				if (dmem_req.wen) begin
					assert (dmem_req.wdata == exp_wdata)
						else value_error($sformatf("store data %h, expected %h",
							dmem_req.wdata, exp_wdata));
				end
				if (dmem_req.ren) begin
					dmem_rdata <= load_word(dmem_req.addr);
				end
				exp_kind = 2'd0;
			end
		end
	end

	initial begin
		int t;
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		t = 0;
		while (n_issued == 0 && t < 4) begin
			@(negedge clk);
			t++;
		end
		if (n_issued == 0) begin
			fail_now("timeout: no instruction fetch after reset");
		end
		t = 0;
		while (n_issued <= N_INST && t < 4 * N_INST) begin
			@(negedge clk);
			t++;
		end
		if (n_issued <= N_INST) begin
			fail_now("timeout: the core stopped fetching instructions");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_core (
	input  wire logic               clk,
	input  wire logic               rst_n,
	output logic                    imem_req,
	output logic [`XLEN-1:0]        imem_addr,
	input  wire logic [31:0]        imem_rdata,
	output rv_core_pkg::dmem_req_t  dmem_req,
	input  wire logic [`XLEN-1:0]   dmem_rdata
);

	rv_core_pkg::dec_t     dec;
	rv_core_pkg::gpr_wr_t  gpr_wr;
	logic [`XLEN-1:0]      pc;
	logic [`XLEN-1:0]      dnpc;
	logic [`XLEN-1:0]      rs1_val;
	logic [`XLEN-1:0]      rs2_val;
	logic [31:0]           inst;
	logic                  jump_en;
	logic                  exec_en;
	logic                  load_wb;
	logic                  is_load;

	assign imem_addr = pc;
	assign is_load   = (dec.cls == rv_core_pkg::OC_IL);

	rv_ifu u_ifu (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_rdata (imem_rdata),
		.jump_en    (jump_en),
		.dnpc       (dnpc),
		.is_load    (is_load),
		.pc         (pc),
		.imem_req   (imem_req),
		.inst       (inst),
		.exec_en    (exec_en),
		.load_wb    (load_wb)
	);

	rv_idu u_idu (
		.inst (inst),
		.dec  (dec)
	);

	rv_gpr u_gpr (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1_idx (dec.rs1),
		.rs2_idx (dec.rs2),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.wr      (gpr_wr)
	);

	rv_exu u_exu (
		.pc         (pc),
		.dec        (dec),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.dmem_rdata (dmem_rdata),
		.exec_en    (exec_en),
		.load_wb    (load_wb),
		.dmem_req   (dmem_req),
		.gpr_wr     (gpr_wr),
		.jump_en    (jump_en),
		.dnpc       (dnpc)
	);

endmodule

`default_nettype wire

/* verilog/rv_ifu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_ifu (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic [31:0]       imem_rdata,
	input  wire logic              jump_en,
	input  wire logic [`XLEN-1:0]  dnpc,
	input  wire logic              is_load,
	output logic [`XLEN-1:0]       pc,
	output logic                   imem_req,
	output logic [31:0]            inst,
	output logic                   exec_en,
	output logic                   load_wb
);

	typedef enum logic [1:0] {
		S_FETCH,
		S_EXEC,
		S_LOAD_WB
	} phase_e;

	phase_e       state;
	phase_e       state_nxt;
	logic [31:0]  inst_q;
	logic         retire;

	assign exec_en = (state == S_EXEC);
	assign load_wb = (state == S_LOAD_WB);
	assign retire  = (exec_en && !is_load) || load_wb;
	assign inst    = exec_en ? imem_rdata : inst_q;    // memory answers during EXEC

	always_comb begin
		case (state)
			S_FETCH:   state_nxt = imem_req ? S_EXEC : S_FETCH;
			S_EXEC:    state_nxt = is_load ? S_LOAD_WB : S_FETCH;
			default:   state_nxt = S_FETCH;
		endcase
	end

	// --------------------------------------------------
	// phase, request strobe and pc

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_FETCH;
			imem_req <= 1'b0;
			pc       <= `RESET_PC;
		end else begin
			state    <= state_nxt;
			imem_req <= (state_nxt == S_FETCH);    // one pulse per fetch
			if (retire) begin
				pc <= jump_en ? dnpc : pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exec_en) begin
			inst_q <= imem_rdata;    // held for the load writeback phase
		end
	end

	// the redirect from execute must keep every fetch word aligned
	assert property (@(posedge clk) disable iff (!rst_n)
		(!imem_req || state == S_FETCH) && (pc[1:0] == 2'b00))
		else $error("fetch request outside FETCH or misaligned pc %h", pc);

endmodule

`default_nettype wire

/* verilog/rv_idu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_idu (
	input  wire logic [31:0]   inst,
	output rv_core_pkg::dec_t  dec
);

	logic [6:0]        opcode;
	logic [6:0]        func7;
	logic [`XLEN-1:0]  imm_i;
	logic [`XLEN-1:0]  imm_s;
	logic [`XLEN-1:0]  imm_b;
	logic [`XLEN-1:0]  imm_u;
	logic [`XLEN-1:0]  imm_j;
	rv_core_pkg::op_class_e cls;

	assign opcode = inst[6:0];
	assign func7  = inst[31:25];

	// --------------------------------------------------
	// immediates, all sign extended from bit 31

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			`OPC_OP:     cls = rv_core_pkg::OC_R;
			`OPC_OPIMM:  cls = rv_core_pkg::OC_I;
			`OPC_LOAD:   cls = rv_core_pkg::OC_IL;
			`OPC_STORE:  cls = rv_core_pkg::OC_S;
			`OPC_BRANCH: cls = rv_core_pkg::OC_B;
			`OPC_LUI:    cls = rv_core_pkg::OC_U;
			`OPC_AUIPC:  cls = rv_core_pkg::OC_UPC;
			`OPC_JAL:    cls = rv_core_pkg::OC_J;
			`OPC_JALR:   cls = rv_core_pkg::OC_JR;
			default:     cls = rv_core_pkg::OC_NOP;    // retires with no effect
		endcase
	end

	always_comb begin
		dec.cls   = cls;
		dec.rd    = inst[11:7];
		dec.rs1   = inst[19:15];
		dec.rs2   = inst[24:20];
		dec.func3 = inst[14:12];
		// for immediates the alt bit only means something on SRAI
		dec.alt   = func7[`F7_ALT] && ((cls == rv_core_pkg::OC_R) ||
			(cls == rv_core_pkg::OC_I && inst[14:12] == `F3_SR));
		case (cls)
			rv_core_pkg::OC_S:   dec.imm = imm_s;
			rv_core_pkg::OC_B:   dec.imm = imm_b;
			rv_core_pkg::OC_U,
			rv_core_pkg::OC_UPC: dec.imm = imm_u;
			rv_core_pkg::OC_J:   dec.imm = imm_j;
			rv_core_pkg::OC_R,
			rv_core_pkg::OC_NOP: dec.imm = '0;
			default:             dec.imm = imm_i;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rv_gpr.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_gpr (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic [4:0]            rs1_idx,
	input  wire logic [4:0]            rs2_idx,
	output logic [`XLEN-1:0]           rs1_val,
	output logic [`XLEN-1:0]           rs2_val,
	input  wire rv_core_pkg::gpr_wr_t  wr
);

	logic [`XLEN-1:0] regs [1:31];    // x0 has no storage

	assign rs1_val = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
	assign rs2_val = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en && wr.addr != 5'd0) begin
			regs[wr.addr] <= wr.data;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_exu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_exu (
	input  wire logic [`XLEN-1:0]   pc,
	input  wire rv_core_pkg::dec_t  dec,
	input  wire logic [`XLEN-1:0]   rs1_val,
	input  wire logic [`XLEN-1:0]   rs2_val,
	input  wire logic [`XLEN-1:0]   dmem_rdata,
	input  wire logic               exec_en,
	input  wire logic               load_wb,
	output rv_core_pkg::dmem_req_t  dmem_req,
	output rv_core_pkg::gpr_wr_t    gpr_wr,
	output logic                    jump_en,
	output logic [`XLEN-1:0]        dnpc
);

	logic [`XLEN-1:0]  snpc;
	logic [`XLEN-1:0]  tgt_pc;
	logic [`XLEN-1:0]  jr_sum;
	logic [`XLEN-1:0]  alu_a;
	logic [`XLEN-1:0]  alu_b;
	logic [`XLEN-1:0]  alu_res;
	logic [`XLEN-1:0]  ld_data;
	logic              alu_eq;
	logic              alu_lt;
	logic              alu_ltu;
	logic              br_taken;
	logic              wb_class;
	rv_core_pkg::alu_op_e alu_op;

	assign snpc   = pc + 32'd4;
	assign tgt_pc = pc + dec.imm;
	assign jr_sum = rs1_val + dec.imm;

	// --------------------------------------------------
	// alu operands and control

	always_comb begin
		case (dec.cls)
			rv_core_pkg::OC_R,
			rv_core_pkg::OC_B:   {alu_a, alu_b} = {rs1_val, rs2_val};
			rv_core_pkg::OC_I,
			rv_core_pkg::OC_IL,
			rv_core_pkg::OC_S:   {alu_a, alu_b} = {rs1_val, dec.imm};
			rv_core_pkg::OC_U:   {alu_a, alu_b} = {dec.imm, {`XLEN{1'b0}}};
			rv_core_pkg::OC_UPC: {alu_a, alu_b} = {pc, dec.imm};
			rv_core_pkg::OC_J,
			rv_core_pkg::OC_JR:  {alu_a, alu_b} = {snpc, {`XLEN{1'b0}}};    // link value
			default:             {alu_a, alu_b} = '0;
		endcase
	end

	always_comb begin
		alu_op = rv_core_pkg::ALU_ADD;    // address and link sums
		if (dec.cls == rv_core_pkg::OC_R || dec.cls == rv_core_pkg::OC_I) begin
			case (dec.func3)
				`F3_ADD:  alu_op = dec.alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
				`F3_SLL:  alu_op = rv_core_pkg::ALU_SLL;
				`F3_SLT:  alu_op = rv_core_pkg::ALU_SLT;
				`F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
				`F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
				`F3_SR:   alu_op = dec.alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
				`F3_OR:   alu_op = rv_core_pkg::ALU_OR;
				default:  alu_op = rv_core_pkg::ALU_AND;
			endcase
		end
	end

	rv_alu u_alu (
		.a   (alu_a),
		.b   (alu_b),
		.op  (alu_op),
		.res (alu_res),
		.eq  (alu_eq),
		.lt  (alu_lt),
		.ltu (alu_ltu)
	);

	// --------------------------------------------------
	// branch decision and redirect

	always_comb begin
		case (dec.func3)
			`F3_BEQ:  br_taken = alu_eq;
			`F3_BNE:  br_taken = !alu_eq;
			`F3_BLT:  br_taken = alu_lt;
			`F3_BGE:  br_taken = !alu_lt;
			`F3_BLTU: br_taken = alu_ltu;
			`F3_BGEU: br_taken = !alu_ltu;
			default:  br_taken = 1'b0;
		endcase
	end

	assign jump_en = (dec.cls == rv_core_pkg::OC_J) || (dec.cls == rv_core_pkg::OC_JR) ||
		(dec.cls == rv_core_pkg::OC_B && br_taken);

	always_comb begin
		if (dec.cls == rv_core_pkg::OC_JR) begin
			dnpc = {jr_sum[`XLEN-1:1], 1'b0};
		end else if (jump_en) begin
			dnpc = tgt_pc;
		end else begin
			dnpc = snpc;
		end
	end

	// --------------------------------------------------
	// memory request

	always_comb begin
		dmem_req.ren  = exec_en && (dec.cls == rv_core_pkg::OC_IL);
		dmem_req.wen  = exec_en && (dec.cls == rv_core_pkg::OC_S);
		dmem_req.addr = alu_res;
		case (dec.func3[1:0])
			2'b00: begin
				dmem_req.mask  = 4'b0001;
				dmem_req.wdata = {4{rs2_val[7:0]}};
			end
			2'b01: begin
				dmem_req.mask  = 4'b0011;
				dmem_req.wdata = {2{rs2_val[15:0]}};
			end
			default: begin
				dmem_req.mask  = 4'b1111;
				dmem_req.wdata = rs2_val;
			end
		endcase
	end

	always_comb begin
		case (dec.func3)
			`F3_B:   ld_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
			`F3_H:   ld_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
			`F3_BU:  ld_data = {24'b0, dmem_rdata[7:0]};
			`F3_HU:  ld_data = {16'b0, dmem_rdata[15:0]};
			default: ld_data = dmem_rdata;
		endcase
	end

	// --------------------------------------------------
	// register writeback

	assign wb_class = (dec.cls == rv_core_pkg::OC_R) || (dec.cls == rv_core_pkg::OC_I) ||
		(dec.cls == rv_core_pkg::OC_U) || (dec.cls == rv_core_pkg::OC_UPC) ||
		(dec.cls == rv_core_pkg::OC_J) || (dec.cls == rv_core_pkg::OC_JR);

	always_comb begin
		gpr_wr.en   = (exec_en && wb_class) || (load_wb && dec.cls == rv_core_pkg::OC_IL);
		gpr_wr.addr = dec.rd;
		gpr_wr.data = load_wb ? ld_data : alu_res;    // loads write one phase later
	end

	always_comb begin
		assert final (!(dmem_req.ren && dmem_req.wen))
			else $error("data memory read and write requested together");
	end

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defs.svh"

module rv_alu (
	input  wire logic [`XLEN-1:0]      a,
	input  wire logic [`XLEN-1:0]      b,
	input  wire rv_core_pkg::alu_op_e  op,
	output logic [`XLEN-1:0]           res,
	output logic                       eq,
	output logic                       lt,
	output logic                       ltu
);

	logic [4:0] shamt;

	assign shamt = b[4:0];
	assign eq    = (a == b);
	assign lt    = ($signed(a) < $signed(b));
	assign ltu   = (a < b);

	always_comb begin
		case (op)
			rv_core_pkg::ALU_ADD:  res = a + b;
			rv_core_pkg::ALU_SUB:  res = a - b;
			rv_core_pkg::ALU_SLL:  res = a << shamt;
			rv_core_pkg::ALU_SLT:  res = {{(`XLEN-1){1'b0}}, lt};
			rv_core_pkg::ALU_SLTU: res = {{(`XLEN-1){1'b0}}, ltu};
			rv_core_pkg::ALU_XOR:  res = a ^ b;
			rv_core_pkg::ALU_SRL:  res = a >> shamt;
			rv_core_pkg::ALU_SRA:  res = $signed(a) >>> shamt;
			rv_core_pkg::ALU_OR:   res = a | b;
			default:               res = a & b;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rv_core_pkg.sv */
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

	typedef enum logic [3:0] {
		OC_R,
		OC_I,
		OC_IL,
		OC_S,
		OC_B,
		OC_U,
		OC_UPC,
		OC_J,
		OC_JR,
		OC_NOP
	} op_class_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef struct packed {
		op_class_e         cls;
		logic [4:0]        rd;
		logic [4:0]        rs1;
		logic [4:0]        rs2;
		logic [2:0]        func3;
		logic              alt;    // selects SUB and SRA
		logic [`XLEN-1:0]  imm;
	} dec_t;

	typedef struct packed {
		logic              en;
		logic [4:0]        addr;
		logic [`XLEN-1:0]  data;
	} gpr_wr_t;

	typedef struct packed {
		logic              ren;
		logic              wen;
		logic [`XLEN-1:0]  addr;
		logic [3:0]        mask;   // bit 0 is the byte at addr
		logic [`XLEN-1:0]  wdata;
	} dmem_req_t;

endpackage

`default_nettype wire

/* verilog/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

`define XLEN        32
`define RESET_PC    32'h8000_0000

// --------------------------------------------------
// major opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OPIMM   7'b0010011
`define OPC_OP      7'b0110011

// --------------------------------------------------
// func3 codes
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F3_B        3'b000
`define F3_H        3'b001
`define F3_W        3'b010
`define F3_BU       3'b100
`define F3_HU       3'b101

`define F7_ALT      5

`endif
